// File: dct_config.svh
//--------------------
// Width and precision settings of the 2-D forward DCT datapath
// Included by the package and by every block that sizes a bus or a shift
//--------------------

`ifndef DCT_CONFIG_SVH
`define DCT_CONFIG_SVH

`define DCT_DW        8                 // Level-shifted input sample
`define DCT_CW        (`DCT_DW + 5)     // After the row pass
`define DCT_C2W       (`DCT_CW + 5)     // After the column pass, full size
`define DCT_QW        (`DCT_DW + 7)     // Output coefficient
`define DCT_COS_FRAC  12                // Fraction bits of the cosine table
`define DCT_OUT_SHIFT 3                 // Column pass to output scaling

`endif

// File: dct_pkg.sv
//--------------------
// Shared types and constant tables of the 2-D DCT
// Coefficient types, the scaled cosine matrix, the JPEG zig-zag scan
// and the state of one ping-pong bank
//--------------------

`include "dct_config.svh"

package dct_pkg;

    typedef logic signed [`DCT_DW-1:0]  sample_t;   // Signed input sample
    typedef logic signed [`DCT_CW-1:0]  coef1_t;    // Row pass result
    typedef logic signed [`DCT_C2W-1:0] coef2_t;    // Column pass result
    typedef logic signed [`DCT_QW-1:0]  qcoef_t;    // Scaled output

    // cos((2n+1)k*pi/16) * 2^12, row 0 carries the extra 1/sqrt(2)
    localparam logic signed [13:0] cos_table [8][8] = '{
        '{ 2896,  2896,  2896,  2896,  2896,  2896,  2896,  2896},
        '{ 4017,  3406,  2276,   799,  -799, -2276, -3406, -4017},
        '{ 3784,  1567, -1567, -3784, -3784, -1567,  1567,  3784},
        '{ 3406,  -799, -4017, -2276,  2276,  4017,   799, -3406},
        '{ 2896, -2896, -2896,  2896,  2896, -2896, -2896,  2896},
        '{ 2276, -4017,   799,  3406, -3406,  -799,  4017, -2276},
        '{ 1567, -3784,  3784, -1567, -1567,  3784, -3784,  1567},
        '{  799, -2276,  3406, -4017,  4017, -3406,  2276,  -799}
    };

    // Scan position i -> row*8 + col of the coefficient block
    localparam logic [5:0] zigzag_order [64] = '{
         0,  1,  8, 16,  9,  2,  3, 10,
        17, 24, 32, 25, 18, 11,  4,  5,
        12, 19, 26, 33, 40, 48, 41, 34,
        27, 20, 13,  6,  7, 14, 21, 28,
        35, 42, 49, 56, 57, 50, 43, 36,
        29, 22, 15, 23, 30, 37, 44, 51,
        58, 59, 52, 45, 38, 31, 39, 46,
        53, 60, 61, 54, 47, 55, 62, 63
    };

    // Life cycle of one bank of a ping-pong memory
    typedef enum logic [1:0] {
        bank_empty,     // Free for the next block
        bank_filling,   // Some rows or columns written
        bank_full,      // Last one written, read not started
        bank_draining   // Read in progress
    } bank_state_e;

endpackage

// File: row_bus_if.sv
//--------------------
// One 8-wide row or column between pipeline blocks
// Carries the beat index and valid/hold flow control
//--------------------

`timescale 1ns/100ps

interface row_bus_if #(
    parameter int W = 13                // Element width
);

    logic signed [W-1:0] row [8];       // Eight elements of one beat
    logic [2:0]          cnt;           // Row or column index
    logic                valid;         // Beat offered
    logic                hold;          // Sink not ready, source must keep the beat

    // Sending block
    modport src (
        output row, cnt, valid,
        input  hold
    );

    // Receiving block
    modport dst (
        input  row, cnt, valid,
        output hold
    );

endinterface

// File: dct_1d.sv
//--------------------
// One 8-point forward DCT pass as a direct constant-matrix product
// Stage 1 registers the row, stage 2 the eight rounded sums
// Used once over rows and once over columns
//--------------------

`timescale 1ns/100ps
`include "dct_config.svh"

module dct_1d #(
    parameter int IW = `DCT_CW,         // Input element width
    parameter int OW = `DCT_C2W         // Output element width
) (
    input logic    clk,
    input logic    reset,
    row_bus_if.dst d,
    row_bus_if.src q
);
    import dct_pkg::*;

    // Product of a 14-bit constant and an input, plus growth of 8 terms
    localparam int prod_w = IW + 14 + 3;
    localparam logic signed [prod_w-1:0] round_c = prod_w'(1) <<< (`DCT_COS_FRAC - 1);

    logic signed [IW-1:0] x_r [8];      // Stage 1 payload
    logic [2:0]           cnt1;
    logic                 v1;
    logic signed [OW-1:0] y_next [8];   // Matrix product of x_r
    logic signed [OW-1:0] y_r [8];      // Stage 2 payload
    logic [2:0]           cnt2;
    logic                 v2;
    logic                 adv;          // Both stages move

    // --------------------
    // Flow control

    // Output full and held freezes the whole pipe
    assign adv    = !(v2 && q.hold);
    assign d.hold = !adv;

    always_ff @(posedge clk) begin
        if (reset) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else if (adv) begin
            v1 <= d.valid;              // Beat accepted when not held
            v2 <= v1;
        end
    end

    // --------------------
    // Datapath

    always_ff @(posedge clk) begin
        if (adv) begin
            x_r  <= d.row;
            cnt1 <= d.cnt;
            y_r  <= y_next;
            cnt2 <= cnt1;               // Index follows its data
        end
    end

    // y[k] = (sum of cos[k][n] * x[n] + 2^11) >>> 12
    always_comb begin
        logic signed [prod_w-1:0] acc;
        for (int k = 0; k < 8; k++) begin
            acc = round_c;
            for (int n = 0; n < 8; n++) begin
                acc = acc + cos_table[k][n] * x_r[n];
            end
            y_next[k] = OW'(acc >>> `DCT_COS_FRAC);  // Truncate to output width
        end
    end

    assign q.row   = y_r;
    assign q.cnt   = cnt2;
    assign q.valid = v2;

endmodule

// File: transpose.sv
//--------------------
// Ping-pong 8x8 transpose memory between the two DCT passes
// Rows are written at their index, columns are read in order
// One bank fills while the other drains
//--------------------

`timescale 1ns/100ps

module transpose (
    input logic    clk,
    input logic    reset,
    row_bus_if.dst d,
    row_bus_if.src q
);
    import dct_pkg::*;

    coef1_t      mem [2][8][8];         // [bank][row][col]
    bank_state_e state [2];
    logic        wr_bank;               // Bank taking rows
    logic        rd_bank;               // Bank giving columns
    logic [2:0]  rd_cnt;                // Column being offered
    logic        wr_go;
    logic        rd_go;

    // --------------------
    // Write side

    // Write bank busy only once both banks hold a block
    assign d.hold = (state[wr_bank] == bank_full) || (state[wr_bank] == bank_draining);
    assign wr_go  = d.valid && !d.hold;

    always_ff @(posedge clk) begin
        if (wr_go) begin
            for (int c = 0; c < 8; c++) begin
                mem[wr_bank][d.cnt][c] <= d.row[c];
            end
        end
    end

    // --------------------
    // Read side

    assign q.valid = (state[rd_bank] == bank_full) || (state[rd_bank] == bank_draining);
    assign q.cnt   = rd_cnt;
    assign rd_go   = q.valid && !q.hold;

    // Column rd_cnt of the read bank, stable while held
    always_comb begin
        for (int r = 0; r < 8; r++) begin
            q.row[r] = mem[rd_bank][r][rd_cnt];
        end
    end

    // Bank states, each side only touches its own bank
    always_ff @(posedge clk) begin
        if (reset) begin
            state[0] <= bank_empty;
            state[1] <= bank_empty;
            wr_bank  <= 1'b0;
            rd_bank  <= 1'b0;
            rd_cnt   <= 3'd0;
        end else begin
            if (wr_go) begin
                if (d.cnt == 3'd7) begin
                    state[wr_bank] <= bank_full;    // Last row in
                    wr_bank        <= ~wr_bank;
                end else begin
                    state[wr_bank] <= bank_filling;
                end
            end
            if (rd_go) begin
                rd_cnt <= rd_cnt + 3'd1;            // Wraps to 0 after column 7
                if (rd_cnt == 3'd7) begin
                    state[rd_bank] <= bank_empty;
                    rd_bank        <= ~rd_bank;
                end else begin
                    state[rd_bank] <= bank_draining;
                end
            end
        end
    end

endmodule

// File: zigzag.sv
//--------------------
// Ping-pong 8x8 reorder memory at the end of the DCT
// Columns are scaled to output width and stored by (v,u)
// Read two coefficients per beat in JPEG zig-zag order
//--------------------

`timescale 1ns/100ps
`include "dct_config.svh"

module zigzag (
    input  logic           clk,
    input  logic           reset,
    row_bus_if.dst         d,
    output dct_pkg::qcoef_t q [2],
    output logic [4:0]     q_cnt,
    output logic           q_valid,
    input  logic           q_hold
);
    import dct_pkg::*;

    localparam int sum_w = `DCT_C2W + 1;                // One guard bit for rounding
    localparam logic signed [sum_w-1:0] round_c = sum_w'(1) <<< (`DCT_OUT_SHIFT - 1);

    qcoef_t               mem [2][64];  // [bank][v*8+u]
    bank_state_e          state [2];
    logic                 wr_bank;
    logic                 rd_bank;
    logic [4:0]           rd_cnt;       // Beat within the scan
    logic signed [sum_w-1:0] rnd [8];
    qcoef_t               scaled [8];
    logic                 wr_go;
    logic                 rd_go;

    // --------------------
    // Write side

    assign d.hold = (state[wr_bank] == bank_full) || (state[wr_bank] == bank_draining);
    assign wr_go  = d.valid && !d.hold;

    // Round half up, then drop to output width
    always_comb begin
        for (int v = 0; v < 8; v++) begin
            rnd[v]    = sum_w'(d.row[v]) + round_c;
            scaled[v] = qcoef_t'(rnd[v] >>> `DCT_OUT_SHIFT);
        end
    end

    // Column u = d.cnt, element v lands at v*8+u
    always_ff @(posedge clk) begin
        if (wr_go) begin
            for (int v = 0; v < 8; v++) begin
                mem[wr_bank][{3'(v), d.cnt}] <= scaled[v];
            end
        end
    end

    // --------------------
    // Read side

    assign q_valid = (state[rd_bank] == bank_full) || (state[rd_bank] == bank_draining);
    assign q_cnt   = rd_cnt;
    assign rd_go   = q_valid && !q_hold;

    always_comb begin
        q[0] = mem[rd_bank][zigzag_order[{rd_cnt, 1'b0}]];  // Scan entry 2*q_cnt
        q[1] = mem[rd_bank][zigzag_order[{rd_cnt, 1'b1}]];  // Scan entry 2*q_cnt+1
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state[0] <= bank_empty;
            state[1] <= bank_empty;
            wr_bank  <= 1'b0;
            rd_bank  <= 1'b0;
            rd_cnt   <= 5'd0;
        end else begin
            if (wr_go) begin
                if (d.cnt == 3'd7) begin
                    state[wr_bank] <= bank_full;
                    wr_bank        <= ~wr_bank;
                end else begin
                    state[wr_bank] <= bank_filling;
                end
            end
            if (rd_go) begin
                rd_cnt <= rd_cnt + 5'd1;
                if (rd_cnt == 5'd31) begin
                    state[rd_bank] <= bank_empty;   // Block fully sent
                    rd_bank        <= ~rd_bank;
                end else begin
                    state[rd_bank] <= bank_draining;
                end
            end
        end
    end

endmodule

// File: dct_2d.sv
//--------------------
// 2-D forward DCT of one 8x8 block, one input row per beat
// Row DCT, transpose, column DCT, zig-zag reorder
// Output is two coefficients per beat in scan order
//--------------------

`timescale 1ns/100ps
`include "dct_config.svh"

module dct_2d (
    input  logic             clk,
    input  logic             reset,
    input  dct_pkg::sample_t di [8],
    input  logic [2:0]       di_cnt,
    input  logic             di_valid,
    output logic             di_hold,
    output dct_pkg::qcoef_t  q [2],
    output logic [4:0]       q_cnt,
    output logic             q_valid,
    input  logic             q_hold
);

    row_bus_if #(.W(`DCT_DW))  in_bus ();   // Plain input ports
    row_bus_if #(.W(`DCT_CW))  row_bus ();  // Row pass to transpose
    row_bus_if #(.W(`DCT_CW))  col_bus ();  // Transpose to column pass
    row_bus_if #(.W(`DCT_C2W)) out_bus ();  // Column pass to zig-zag

    assign in_bus.row   = di;
    assign in_bus.cnt   = di_cnt;
    assign in_bus.valid = di_valid;
    assign di_hold      = in_bus.hold;

    // --------------------
    // Pipeline

    dct_1d #(.IW(`DCT_DW), .OW(`DCT_CW)) u_dct_row (
        .clk   (clk),
        .reset (reset),
        .d     (in_bus.dst),
        .q     (row_bus.src)
    );

    transpose u_transpose (
        .clk   (clk),
        .reset (reset),
        .d     (row_bus.dst),
        .q     (col_bus.src)
    );

    dct_1d #(.IW(`DCT_CW), .OW(`DCT_C2W)) u_dct_col (
        .clk   (clk),
        .reset (reset),
        .d     (col_bus.dst),
        .q     (out_bus.src)
    );

    zigzag u_zigzag (
        .clk     (clk),
        .reset   (reset),
        .d       (out_bus.dst),
        .q       (q),
        .q_cnt   (q_cnt),
        .q_valid (q_valid),
        .q_hold  (q_hold)           // Back-pressure from the output port
    );

endmodule

// File: tb_dct_2d.sv
//--------------------
// Self-checking testbench of the 2-D DCT
// Feeds a table of 8x8 blocks back to back, checks every zig-zag beat
// against an integer model, with output back-pressure per entry
//--------------------

`timescale 1ns/100ps

module tb_dct_2d;
    import dct_pkg::*;

    localparam int n_tests   = 8;
    localparam int cyc_limit = 400 * n_tests + 16;     // Reset cycles included
    localparam int k_zero    = 0;                       // Block kinds
    localparam int k_flat    = 1;
    localparam int k_imp     = 2;
    localparam int k_ramp    = 3;
    localparam int k_rand    = 4;
    localparam int h_none    = 0;                       // q_hold patterns
    localparam int h_alt     = 1;
    localparam int h_rand    = 2;

    // --------------------
    // Stimulus table, one entry per test
    string t_name  [n_tests] = '{"zero", "flat_10", "flat_m20", "impulse_dc",
                                 "impulse_27", "ramp", "random_a", "random_b"};
    int    t_kind  [n_tests] = '{k_zero, k_flat, k_flat, k_imp, k_imp, k_ramp, k_rand, k_rand};
    int    t_val   [n_tests] = '{0, 10, -20, 100, -64, 0, 0, 0};  // Level or impulse height
    int    t_pos   [n_tests] = '{0, 0, 0, 0, 27, 0, 0, 0};        // Impulse at r*8+c
    int    t_hold  [n_tests] = '{h_none, h_none, h_alt, h_none, h_alt, h_rand, h_rand, h_rand};
    int    t_dc    [n_tests] = '{0, 40, -80, 0, 0, 0, 0, 0};      // Expected DC
    bit    t_fixed [n_tests] = '{1, 1, 1, 0, 0, 0, 0, 0};         // DC known, AC all zero

    logic       clk;
    logic       reset;
    sample_t    di [8];
    logic [2:0] di_cnt;
    logic       di_valid;
    logic       di_hold;
    qcoef_t     q [2];
    logic [4:0] q_cnt;
    logic       q_valid;
    logic       q_hold;

    int exp_q [$];                      // Expected coefficients in scan order
    int errors      = 0;
    int rows_in     = 0;
    int blocks_in   = 0;
    int blocks_out  = 0;
    int out_test    = 0;                // Entry whose output is draining
    int cycles      = 0;
    bit saw_di_hold = 1'b0;

    dct_2d u_dct_2d (
        .clk      (clk),
        .reset    (reset),
        .di       (di),
        .di_cnt   (di_cnt),
        .di_valid (di_valid),
        .di_hold  (di_hold),
        .q        (q),
        .q_cnt    (q_cnt),
        .q_valid  (q_valid),
        .q_hold   (q_hold)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    // Run limit
    initial begin
        while (cycles < cyc_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d of %0d blocks delivered", cycles, blocks_out,
                 n_tests);
        $display("RESULT: FAIL");
        $finish;
    end

    // Output back-pressure follows the entry being drained
    always @(posedge clk) begin
        if (reset) begin
            q_hold <= 1'b0;
        end else begin
            case (t_hold[out_test])
                h_alt:   q_hold <= ~q_hold;
                h_rand:  q_hold <= 1'($urandom & 32'h1);  // 50 %
                default: q_hold <= 1'b0;
            endcase
        end
    end

    // Rows and blocks that actually cross the DUT ports
    always @(negedge clk) begin
        if (!reset && di_valid && !di_hold) begin
            rows_in++;
            if (di_cnt == 3'd7) blocks_in++;
        end
        if (!reset && q_valid && !q_hold && q_cnt == 5'd31) blocks_out++;  // Last beat
    end

    // Sign-extend the low w bits, as a truncation to a w-bit register does
    function automatic int sext(input int v, input int w);
        int s;
        s = 32 - w;
        return (v <<< s) >>> s;
    endfunction

    // Integer model, row pass then column pass then output scaling
    function automatic void model_block(input int x [8][8], output int zz [64]);
        int t [8][8];                   // [r][u] after the row pass
        int f [64];                     // Output at v*8+u
        int acc;
        int c;
        for (int r = 0; r < 8; r++) begin
            for (int u = 0; u < 8; u++) begin
                acc = 2048;             // Half of 2^12
                for (int n = 0; n < 8; n++) begin
                    c = cos_table[u][n];
                    acc += c * x[r][n];
                end
                t[r][u] = sext(acc >>> 12, 13);
            end
        end
        for (int u = 0; u < 8; u++) begin
            for (int v = 0; v < 8; v++) begin
                acc = 2048;
                for (int r = 0; r < 8; r++) begin
                    c = cos_table[v][r];
                    acc += c * t[r][u];
                end
                f[v * 8 + u] = sext((sext(acc >>> 12, 18) + 4) >>> 3, 15);
            end
        end
        for (int i = 0; i < 64; i++) zz[i] = f[zigzag_order[i]];
    endfunction

    task automatic report_value(input string sig, input int exp_v, input int act_v);
        $display("[ERROR] %0t %s expected %0d actual %0d", $time, sig, exp_v, act_v);
        errors++;
    endtask

    // Nothing moves while no block is in flight
    task automatic check_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (!q_valid) else report_value("q_valid", 0, int'(q_valid));
            assert (!di_hold) else report_value("di_hold", 0, int'(di_hold));
            assert (q_cnt == 5'd0) else report_value("q_cnt", 0, int'(q_cnt));
        end
    endtask

    // Build one block, queue its model result, feed rows 0..7
    task automatic send_block(input int t);
        int x [8][8];
        int zz [64];
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                case (t_kind[t])
                    k_flat:  x[r][c] = t_val[t];
                    k_imp:   x[r][c] = (r * 8 + c == t_pos[t]) ? t_val[t] : 0;
                    k_ramp:  x[r][c] = (r * 8 + c) * 3 - 96;
                    k_rand:  x[r][c] = int'($urandom & 32'hff) - 128;
                    default: x[r][c] = 0;
                endcase
            end
        end
        model_block(x, zz);
        if (t_fixed[t]) begin
            assert (zz[0] == t_dc[t]) else begin
                $display("Model DC %0d of test %s differs from table DC %0d", zz[0],
                         t_name[t], t_dc[t]);
                errors++;
            end
        end
        foreach (zz[i]) exp_q.push_back(zz[i]);
        for (int r = 0; r < 8; r++) begin
            @(posedge clk);
            for (int c = 0; c < 8; c++) di[c] <= sample_t'(x[r][c]);
            di_cnt   <= 3'(r);
            di_valid <= 1'b1;
            do begin
                @(negedge clk);
                if (di_hold) saw_di_hold = 1'b1;    // Input throttled
            end while (di_hold);
        end
    endtask

    // Check every transferred beat, and stability while held
    task automatic collect_outputs();
        int         beat;
        int         err0;
        int         e0;
        int         e1;
        int         a0;
        int         a1;
        bit         held;
        qcoef_t     p0;
        qcoef_t     p1;
        logic [4:0] pcnt;
        held = 1'b0;
        for (int b = 0; b < n_tests; b++) begin
            out_test = b;
            beat     = 0;
            err0     = errors;
            while (beat < 32) begin
                @(negedge clk);
                if (held) begin
                    assert (q_valid) else report_value("q_valid", 1, int'(q_valid));
                    assert (q_cnt == pcnt) else report_value("q_cnt", int'(pcnt), int'(q_cnt));
                    assert (q[0] == p0) else report_value("q[0]", int'(p0), int'(q[0]));
                    assert (q[1] == p1) else report_value("q[1]", int'(p1), int'(q[1]));
                end
                held = q_valid && q_hold;
                p0   = q[0];
                p1   = q[1];
                pcnt = q_cnt;
                if (q_valid && !q_hold) begin
                    if (exp_q.size() < 2) begin
                        $display("Output beat at %0t with no block pending", $time);
                        errors++;
                    end else begin
                        e0 = exp_q.pop_front();
                        e1 = exp_q.pop_front();
                        a0 = q[0];
                        a1 = q[1];
                        assert (q_cnt == 5'(beat)) else report_value("q_cnt", beat, int'(q_cnt));
                        assert (a0 == e0) else report_value("q[0]", e0, a0);
                        assert (a1 == e1) else report_value("q[1]", e1, a1);
                        if (t_fixed[b]) begin
                            assert (a0 == ((beat == 0) ? t_dc[b] : 0)) else
                                report_value("q[0]", (beat == 0) ? t_dc[b] : 0, a0);
                            assert (a1 == 0) else report_value("q[1]", 0, a1);
                        end
                    end
                    beat++;
                end
            end
            $display("Test %0d %s, hold mode %0d, 32 beats, %0d errors", b, t_name[b],
                     t_hold[b], errors - err0);
        end
    endtask

    // --------------------
    // Main sequence
    initial begin
        void'($urandom(32'h3331));          // One seed for the run
        reset    = 1'b1;
        di_cnt   = 3'd0;
        di_valid = 1'b0;
        q_hold   = 1'b0;
        for (int c = 0; c < 8; c++) di[c] = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        check_idle(20);
        fork
            begin
                for (int t = 0; t < n_tests; t++) send_block(t);
                @(posedge clk);
                di_valid <= 1'b0;
            end
            collect_outputs();
        join
        check_idle(40);                     // No extra beat after the last block
        assert (blocks_in == n_tests && blocks_out == blocks_in && rows_in == 8 * n_tests)
            else begin
            $display("Blocks accepted %0d and delivered %0d disagree, rows %0d", blocks_in,
                     blocks_out, rows_in);
            errors++;
        end
        assert (saw_di_hold) else begin
            $display("Input was never held back while the output was stalled");
            errors++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d expected coefficients were never delivered", exp_q.size());
            errors++;
        end
        $display("Tests %0d, blocks in %0d, blocks out %0d, errors %0d", n_tests, blocks_in,
                 blocks_out, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
dct_pkg.sv
row_bus_if.sv
dct_1d.sv
transpose.sv
zigzag.sv
dct_2d.sv
tb_dct_2d.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and grep the result line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_dct_2d -o sim_dct
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_dct)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "RESULT: PASS"; then
    exit 0
fi
exit 1
